// ==== bench/fiber_filler_props.sv ====
`timescale 1ns/1ns

`include "filler_defs.svh"

module fiber_filler_props
	import grid_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic [$bits(`SYNC_PATTERN)-1:0] sync_word,
	input seq_state_t state,
	input logic fill_en,
	input logic frame_valid
);

	// Strobe rises on the 17th edge after arming
	localparam int STROBE_DELAY = `FILL_CYCLES + 1;

	int prop_failures = 0;
	logic accepted;

	// Match only counts while idle
	assign accepted = (state == SEQ_IDLE) && (sync_word == `SYNC_PATTERN);

	property p_single_pulse;
		@(posedge clk) disable iff (!rst_n)
		frame_valid |=> !frame_valid;
	endproperty

	property p_strobe_delay;
		@(posedge clk) disable iff (!rst_n)
		accepted |=> !frame_valid [*STROBE_DELAY] ##1 frame_valid;
	endproperty

	property p_no_overlap;
		@(posedge clk) disable iff (!rst_n)
		!(fill_en && frame_valid);
	endproperty

	property p_reset_low;
		@(posedge clk)
		!rst_n |=> !frame_valid;
	endproperty

	a_single_pulse: assert property (p_single_pulse)
	else
	begin
		prop_failures++;
		$error("frame_valid stayed high for more than one cycle");
	end

	a_strobe_delay: assert property (p_strobe_delay)
	else
	begin
		prop_failures++;
		$error("frame_valid did not rise exactly 17 cycles after an accepted sync word");
	end

	a_no_overlap: assert property (p_no_overlap)
	else
	begin
		prop_failures++;
		$error("fill_en and frame_valid were high in the same cycle");
	end

	a_reset_low: assert property (p_reset_low)
	else
	begin
		prop_failures++;
		$error("frame_valid was high while reset was active");
	end

endmodule

// ==== bench/fiber_filler_tb.sv ====
`timescale 1ns/1ns

`include "filler_defs.svh"

module fiber_filler_tb
	import hit_pkg::*;
	import grid_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 40;
	localparam int MODE_VALID = 0;
	localparam int MODE_INVALID = 1;
	localparam int MODE_MIXED = 2;

	logic clk;
	logic rst_n;
	logic [$bits(`SYNC_PATTERN)-1:0] sync_word;
	channel_bus_t channels;
	grid_t grid;
	logic frame_valid;

	grid_t model_grid;
	integer seed;
	int errors;
	int timeouts;
	int pulse_count;

	fiber_filler fiber_filler_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.sync_word(sync_word),
		.channels(channels),
		.grid(grid),
		.frame_valid(frame_valid)
	);

	bind frame_sequencer fiber_filler_props fiber_filler_props_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.sync_word(sync_word),
		.state(state),
		.fill_en(fill_en),
		.frame_valid(frame_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2 clk = ~clk;
		end
	end

	// Strobes counted mid-cycle, away from the edges
	always @(negedge clk)
	begin
		if (rst_n === 1'b1 && frame_valid === 1'b1)
		begin
			pulse_count++;
		end
	end

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic coord_t rand_in_range();
		return coord_t'(rand_word() % `COORD_LIMIT);
	endfunction

	function automatic coord_t rand_out_of_range();
		return coord_t'(`COORD_LIMIT + rand_word() % ((1 << `COORD_W) - `COORD_LIMIT));
	endfunction

	function automatic logic [$bits(`SYNC_PATTERN)-1:0] non_sync();
		logic [31:0] raw;
		logic [$bits(`SYNC_PATTERN)-1:0] w;
		raw = rand_word();
		w = raw[$bits(`SYNC_PATTERN)-1:0];
		if (w == `SYNC_PATTERN)
		begin
			w = ~w;
		end
		return w;
	endfunction

	function automatic hit_word_t junk_word();
		logic [31:0] raw;
		raw = rand_word();
		return hit_word_t'(raw[$bits(hit_word_t)-1:0]);
	endfunction

	// Mixed picks valid or invalid per channel
	function automatic hit_word_t make_word(input int mode);
		hit_word_t w;
		logic [31:0] pick;
		int kind;
		pick = rand_word();
		kind = mode;
		if (mode == MODE_MIXED)
		begin
			kind = pick[0] ? MODE_VALID : MODE_INVALID;
		end
		w.hit = 1'b1;
		w.x = rand_in_range();
		w.y = rand_in_range();
		if (kind == MODE_INVALID)
		begin
			case (pick[2:1])
				2'd0:
				begin
					w.hit = 1'b0;
					w.x = coord_t'(rand_word());
					w.y = coord_t'(rand_word());
				end
				2'd1: w.x = rand_out_of_range();
				2'd2: w.y = rand_out_of_range();
				default:
				begin
					w.x = rand_out_of_range();
					w.y = rand_out_of_range();
				end
			endcase
		end
		return w;
	endfunction

	task automatic model_add(input hit_word_t w);
		int row;
		int col;
		if (w.hit && w.x < `COORD_LIMIT && w.y < `COORD_LIMIT)
		begin
			// Cell sits one step inside the border
			row = int'(w.y) + 1;
			col = int'(w.x) + 1;
			model_grid[row][col] = 1'b1;
		end
	endtask

	function automatic int border_count(input grid_t g);
		int n;
		n = 0;
		for (int r = 0; r < `GRID_DIM; r++)
		begin
			for (int c = 0; c < `GRID_DIM; c++)
			begin
				if ((r == 0 || r == `GRID_DIM - 1 || c == 0 || c == `GRID_DIM - 1) && g[r][c])
				begin
					n++;
				end
			end
		end
		return n;
	endfunction

	task automatic check_grid(input grid_t expected);
		assert (grid === expected)
		else
		begin
			errors++;
			$display("[ERROR] %0t grid: expected %h, got %h", $time, expected, grid);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected)
		else
		begin
			errors++;
			$display("[ERROR] %0t %s: expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_int(input string name, input int expected, input int actual);
		assert (actual == expected)
		else
		begin
			errors++;
			$display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic drive_idle();
		sync_word = non_sync();
		for (int ch = 0; ch < `NUM_CHANNELS; ch++)
		begin
			channels[ch] = junk_word();
		end
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++)
		begin
			drive_idle();
			tick();
			check_bit("frame_valid", 1'b0, frame_valid);
			check_grid('0);
		end
	endtask

	// One frame, with the sync word optionally held through the fill
	task automatic run_frame(input int mode, input bit hold_sync);
		int start_pulses;
		int waited;
		start_pulses = pulse_count;
		model_grid = '0;
		sync_word = `SYNC_PATTERN;
		tick();
		if (!hold_sync)
		begin
			sync_word = non_sync();
		end
		for (int c = 0; c < `FILL_CYCLES; c++)
		begin
			for (int ch = 0; ch < `NUM_CHANNELS; ch++)
			begin
				channels[ch] = make_word(mode);
				model_add(channels[ch]);
			end
			tick();
		end
		for (int ch = 0; ch < `NUM_CHANNELS; ch++)
		begin
			channels[ch] = junk_word();
		end
		waited = 0;
		while (frame_valid !== 1'b1 && waited < TIMEOUT_CYCLES)
		begin
			tick();
			waited++;
		end
		if (frame_valid !== 1'b1)
		begin
			timeouts++;
			$display("Timeout: frame_valid did not arrive within %0d cycles at %0t",
				TIMEOUT_CYCLES, $time);
			sync_word = non_sync();
			return;
		end
		check_int("frame_valid latency", `FILL_CYCLES + 1, `FILL_CYCLES + waited);
		check_grid(model_grid);
		check_int("grid border cells", 0, border_count(grid));
		sync_word = non_sync();
		tick();
		// Wiped on the edge that ends the strobe
		check_bit("frame_valid", 1'b0, frame_valid);
		check_grid('0);
		// Long enough for a second frame armed during this one to strobe
		idle_cycles(`FILL_CYCLES + 4);
		check_int("frame_valid pulses", 1, pulse_count - start_pulses);
	endtask

	initial
	begin
		seed = 40199;
		errors = 0;
		timeouts = 0;
		pulse_count = 0;
		rst_n = 1'b0;
		sync_word = '0;
		channels = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		idle_cycles(20);
		run_frame(MODE_VALID, 1'b0);
		run_frame(MODE_INVALID, 1'b0);
		run_frame(MODE_MIXED, 1'b0);
		run_frame(MODE_VALID, 1'b1);
		run_frame(MODE_MIXED, 1'b1);
		for (int f = 0; f < 3; f++)
		begin
			run_frame(MODE_VALID, 1'b0);
		end

		$display("errors: %0d, timeouts: %0d, assertion failures: %0d",
			errors, timeouts,
			fiber_filler_inst.frame_sequencer_inst.fiber_filler_props_inst.prop_failures);
		if (errors == 0 && timeouts == 0 &&
			fiber_filler_inst.frame_sequencer_inst.fiber_filler_props_inst.prop_failures == 0)
		begin
			$display("sim passed");
		end
		else
		begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== common/filler_defs.svh ====
`ifndef FILLER_DEFS_SVH
`define FILLER_DEFS_SVH

// Side of the square occupancy grid
// Rows and columns 0 and GRID_DIM-1 form an empty border
`define GRID_DIM 38

// Detector channels sampled in parallel on every fill cycle
`define NUM_CHANNELS 16

// Sampling cycles per frame after arming
`define FILL_CYCLES 16

// Arming word, alternating ones and zeros starting at the MSB
`define SYNC_PATTERN 16'hAAAA

// Width of one x or y coordinate in a channel word
`define COORD_W 6

// First coordinate that falls outside the fillable area
`define COORD_LIMIT 36

`endif

// ==== common/grid_pkg.sv ====
`include "filler_defs.svh"

package grid_pkg;

	// One grid row, bit index is the column
	typedef logic [`GRID_DIM-1:0] grid_row_t;

	// Whole occupancy grid, first index is the row
	typedef grid_row_t [`GRID_DIM-1:0] grid_t;

	// Frame sequencer states
	// idle    waiting for the sync word
	// fill    sampling channels
	// present settle cycle, then the frame strobe
	typedef enum logic [1:0]
	{
		SEQ_IDLE = 2'd0,
		SEQ_FILL = 2'd1,
		SEQ_PRESENT = 2'd2
	} seq_state_t;

endpackage

// ==== common/hit_pkg.sv ====
`include "filler_defs.svh"

package hit_pkg;

	// One x or y coordinate as carried on a channel
	typedef logic [`COORD_W-1:0] coord_t;

	// Channel word layout
	// bit 12 hit flag, bits 11:6 column, bits 5:0 row
	typedef struct packed
	{
		logic hit;
		coord_t x;
		coord_t y;
	} hit_word_t;

	// All channel words of one sampling cycle
	typedef hit_word_t [`NUM_CHANNELS-1:0] channel_bus_t;

	// True when a coordinate maps inside the fillable area
	function automatic logic coord_ok(input coord_t c);
		return c < coord_t'(`COORD_LIMIT);
	endfunction

	// A hit that lands in the grid
	function automatic logic hit_ok(input hit_word_t w);
		return w.hit && coord_ok(w.x) && coord_ok(w.y);
	endfunction

endpackage

// ==== fiber_filler.f ====
+incdir+common
common/hit_pkg.sv
common/grid_pkg.sv
src/frame_sequencer.sv
occupancy/hit_decoder.sv
occupancy/occupancy_grid.sv
src/fiber_filler.sv
bench/fiber_filler_props.sv
bench/fiber_filler_tb.sv

// ==== occupancy/hit_decoder.sv ====
`timescale 1ns/1ns

`include "filler_defs.svh"

module hit_decoder
	import hit_pkg::*;
	import grid_pkg::*;
(
	input channel_bus_t channels,
	output grid_t set_mask
);

	// Per channel acceptance and one-hot row and column selects
	logic [`NUM_CHANNELS-1:0] ch_valid;
	grid_row_t row_sel [`NUM_CHANNELS];
	grid_row_t col_sel [`NUM_CHANNELS];

	// One-hot select for a coordinate, shifted past the border cell
	function automatic grid_row_t cell_sel(input coord_t c);
		grid_row_t sel;
		sel = '0;
		sel[c + 1'b1] = 1'b1;
		return sel;
	endfunction

	genvar ch;
	generate
		for (ch = 0; ch < `NUM_CHANNELS; ch++)
		begin : g_channel
			hit_word_t word;

			assign word = channels[ch];

			// Flag set and both coordinates inside the fillable area
			assign ch_valid[ch] = hit_ok(word);

			always_comb
			begin
				if (ch_valid[ch])
				begin
					row_sel[ch] = cell_sel(word.y);
					col_sel[ch] = cell_sel(word.x);
				end
				else
				begin
					row_sel[ch] = '0;
					col_sel[ch] = '0;
				end
			end
		end
	endgenerate

	// Each row collects the columns of every channel that picks it
	// so several channels may land on one cell
	genvar r;
	generate
		for (r = 0; r < `GRID_DIM; r++)
		begin : g_row
			always_comb
			begin
				set_mask[r] = '0;
				for (int i = 0; i < `NUM_CHANNELS; i++)
				begin
					if (row_sel[i][r])
					begin
						set_mask[r] = set_mask[r] | col_sel[i];
					end
				end
			end
		end
	endgenerate

endmodule

// ==== occupancy/occupancy_grid.sv ====
`timescale 1ns/1ns

`include "filler_defs.svh"

module occupancy_grid
	import hit_pkg::*;
	import grid_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic fill_en,
	input logic clear,
	input grid_t set_mask,
	output grid_t grid
);

	grid_t grid_q;
	grid_t grid_next;

	// Hits only ever add bits within one frame
	always_comb
	begin
		grid_next = grid_q;
		if (fill_en)
		begin
			grid_next = grid_q | set_mask;
		end
	end

	// Row registers
	// whole grid wiped on reset and at end of frame
	genvar r;
	generate
		for (r = 0; r < `GRID_DIM; r++)
		begin : g_row
			always_ff @(posedge clk)
			begin
				if (!rst_n)
				begin
					grid_q[r] <= '0;
				end
				else if (clear)
				begin
					grid_q[r] <= '0;
				end
				else
				begin
					grid_q[r] <= grid_next[r];
				end
			end
		end
	endgenerate

	assign grid = grid_q;

endmodule

// ==== src/fiber_filler.sv ====
`timescale 1ns/1ns

`include "filler_defs.svh"

module fiber_filler
	import hit_pkg::*;
	import grid_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic [$bits(`SYNC_PATTERN)-1:0] sync_word,
	input channel_bus_t channels,
	output grid_t grid,
	output logic frame_valid
);

	// Sequencer to grid controls
	logic fill_en;
	logic clear;

	// Cells hit in the current sampling cycle
	grid_t set_mask;

	frame_sequencer frame_sequencer_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.sync_word(sync_word),
		.fill_en(fill_en),
		.clear(clear),
		.frame_valid(frame_valid)
	);

	hit_decoder hit_decoder_inst
	(
		.channels(channels),
		.set_mask(set_mask)
	);

	occupancy_grid occupancy_grid_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.fill_en(fill_en),
		.clear(clear),
		.set_mask(set_mask),
		.grid(grid)
	);

endmodule

// ==== src/frame_sequencer.sv ====
`timescale 1ns/1ns

`include "filler_defs.svh"

module frame_sequencer
	import grid_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic [$bits(`SYNC_PATTERN)-1:0] sync_word,
	output logic fill_en,
	output logic clear,
	output logic frame_valid
);

	localparam int CNT_W = $clog2(`FILL_CYCLES);
	localparam logic [CNT_W-1:0] LAST_FILL = CNT_W'(`FILL_CYCLES - 1);

	seq_state_t state;
	logic [CNT_W-1:0] fill_cnt;
	logic strobe_q;
	logic sync_match;

	assign sync_match = (sync_word == `SYNC_PATTERN);

	// Grid samples hits on every edge while filling
	assign fill_en = (state == SEQ_FILL);

	// Frame is shown and wiped in the same cycle
	assign frame_valid = strobe_q;
	assign clear = strobe_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= SEQ_IDLE;
			fill_cnt <= '0;
			strobe_q <= 1'b0;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
				begin
					// Only an idle block can be armed
					if (sync_match)
					begin
						state <= SEQ_FILL;
						fill_cnt <= '0;
					end
				end
				SEQ_FILL:
				begin
					if (fill_cnt == LAST_FILL)
					begin
						state <= SEQ_PRESENT;
					end
					else
					begin
						fill_cnt <= fill_cnt + 1'b1;
					end
				end
				SEQ_PRESENT:
				begin
					// First cycle lets the last fill settle, second one strobes
					if (!strobe_q)
					begin
						strobe_q <= 1'b1;
					end
					else
					begin
						strobe_q <= 1'b0;
						state <= SEQ_IDLE;
					end
				end
				default:
				begin
					state <= SEQ_IDLE;
					strobe_q <= 1'b0;
				end
			endcase
		end
	end

endmodule
